//--- vlog.f
+incdir+source
+incdir+bench
source/core_pkg.sv
source/reg_file.sv
source/insn_decode.sv
source/alu_exec.sv
source/result_commit.sv
source/int_core.sv
bench/int_core_tb.sv

//--- Bender.yml
package:
  name: int_core

sources:
  - include_dirs:
      - source
    files:
      - source/core_pkg.sv
      - source/reg_file.sv
      - source/insn_decode.sv
      - source/alu_exec.sv
      - source/result_commit.sv
      - source/int_core.sv
  - target: test
    include_dirs:
      - source
      - bench
    files:
      - bench/int_core_tb.sv

//--- bench/tb_model.svh
// reference model for the integer core testbench
// results, flags, predicate rule and an xorshift generator

`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

function automatic logic [63:0] xorshift(input logic [63:0] x);
  logic [63:0] s;
  s = x ^ (x << 13);
  s = s ^ (s >> 7);
  return s ^ (s << 17);
endfunction

// result, carry and overflow of one operation
function automatic void compute(input logic [4:0] op, input logic [63:0] a, b,
                                output logic [63:0] res, output logic c, v);
  logic [64:0] sum;
  logic [63:0] bb;
  c = 1'b0;
  v = 1'b0;
  bb = (op == op_add) ? b : ~b;
  sum = {1'b0, a} + {1'b0, bb} + 65'(op != op_add);
  case (op)
    op_add, op_sub, op_cmp: begin
      res = sum[63:0];
      c = sum[64];
      v = (a[63] == bb[63]) && (res[63] != a[63]);
    end
    op_and: res = a & b;
    op_or:  res = a | b;
    op_xor: res = a ^ b;
    op_shl: res = a << b[5:0];
    op_shr: res = a >> b[5:0];
    op_sar: res = $signed(a) >>> b[5:0];
    op_mov: res = b;
    op_sxt: begin
      case (b[1:0])
        2'd0:    res = 64'($signed(a[7:0]));
        2'd1:    res = 64'($signed(a[15:0]));
        2'd2:    res = 64'($signed(a[31:0]));
        default: res = {32'd0, a[7:0], a[15:8], a[23:16], a[31:24]};  // byte swap
      endcase
    end
    default: res = '0;  // no-op
  endcase
endfunction

function automatic flags_t flags_of(input logic [63:0] res, input logic c, v);
  flags_t f;
  f.c = c;
  f.v = v;
  f.n = res[63];
  f.z = (res == 64'd0);
  return f;
endfunction

// conditions come in pairs, the odd one is the inverse
function automatic logic cond_holds(input logic [3:0] cond, input flags_t f);
  logic t;
  case (cond[3:1])
    3'd0:    t = f.z;
    3'd1:    t = f.c;
    3'd2:    t = f.n;
    3'd3:    t = f.v;
    3'd4:    t = f.c & ~f.z;
    3'd5:    t = (f.n == f.v);
    3'd6:    t = ~f.z & (f.n == f.v);
    default: t = 1'b1;
  endcase
  return t ^ cond[0];
endfunction

`endif

//--- bench/int_core_tb.sv
// testbench for the integer core
// directed and random instructions checked against a shadow model

`timescale 1ns/1ps

`include "core_defs.svh"

module int_core_tb import core_pkg::*; ();

  localparam int PERIOD   = 8;
  localparam int RESET_CY = 8;
  localparam int GAP      = `CORE_LATENCY;  // idle cycles after a spaced issue
  localparam int N_ARITH  = 12;
  localparam int N_LOGIC  = 4;
  localparam int N_INSN   = 1 + N_ARITH * 17 + 1 + N_LOGIC * 27 + 5 + 64 * 3 + 40 + 6;

  logic        clk;
  logic        rst;
  logic        insn_valid;
  insn_t       insn;
  retire_t     retire;
  logic [63:0] shadow [`CORE_NREGS];
  flags_t      shadow_flags;
  retire_t     exp_q [$];
  string       name_q [$];
  string       test_name;
  logic [63:0] rng_state;
  int          errors;
  int          checks;
  int          issued;

  `include "tb_model.svh"

  int_core int_core_i (.clk, .rst, .insn_valid, .insn, .retire);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    #((RESET_CY + N_INSN * (GAP + 1) + 200) * PERIOD);
    $display("watchdog expired before the tests finished");
    $display("TEST FAILED");
    $finish;
  end

  // each issue retires CORE_LATENCY edges later
  property retire_after_issue;
    @(posedge clk) disable iff (rst) insn_valid |-> ##(`CORE_LATENCY) retire.valid;
  endproperty

  property issue_before_retire;
    @(posedge clk) disable iff (rst) retire.valid |-> $past(insn_valid, `CORE_LATENCY);
  endproperty

  assert property (retire_after_issue) else begin
    errors++;
    $display("no retire %0d edges after an issue", `CORE_LATENCY);
  end

  assert property (issue_before_retire) else begin
    errors++;
    $display("retire without a matching issue");
  end

  task automatic compare(input string name, field, input logic [63:0] want, got);
    checks++;
    assert (want === got) else begin
      errors++;
      $display("** Error [%s] %s: expected %h, actual %h", name, field, want, got);
    end
  endtask

  task automatic require(input logic ok, input string what);
    checks++;
    assert (ok) else begin
      errors++;
      $display("%s", what);
    end
  endtask

  function automatic logic [63:0] rand64();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  function automatic insn_t build(input opcode_e op, input logic [3:0] rd, ra, rb,
                                  input logic use_imm, input logic [16:0] imm);
    insn_t i;
    i.opcode    = op;
    i.use_imm   = use_imm;
    i.rd        = rd;
    i.ra        = ra;
    i.rb        = rb;
    i.cond      = al;
    i.set_flags = 1'b1;
    i.imm       = imm;
    return i;
  endfunction

  task automatic idle(input int n);
    @(negedge clk);
    insn_valid = 1'b0;
    repeat (n - 1) @(negedge clk);
  endtask

  // drive one instruction and queue what it should retire with
  task automatic issue(input insn_t i, input int gap);
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] res;
    logic        c;
    logic        v;
    logic        pass;
    logic        known;
    retire_t     e;
    @(negedge clk);
    insn       = i;
    insn_valid = 1'b1;
    a = shadow[i.ra];
    b = i.use_imm ? 64'($signed(i.imm)) : shadow[i.rb];
    compute(i.opcode, a, b, res, c, v);
    known = i.opcode inside {op_add, op_sub, op_cmp, op_and, op_or, op_xor,
                             op_shl, op_shr, op_sar, op_mov, op_sxt};
    pass  = cond_holds(i.cond, shadow_flags);
    e.valid       = 1'b1;
    e.rd          = i.rd;
    e.data        = res;
    e.flags       = flags_of(res, c, v);
    e.write       = pass && known && (i.opcode != op_cmp);
    e.flags_write = pass && known && (i.set_flags || i.opcode == op_cmp);
    if (e.write) begin
      shadow[i.rd] = res;
    end
    if (e.flags_write) begin
      shadow_flags = e.flags;
    end
    exp_q.push_back(e);
    name_q.push_back(test_name);
    issued++;
    if (gap > 0) begin
      idle(gap);
    end
  endtask

  // immediates are 17 bits, so build the value 16 bits at a time
  task automatic load_reg(input logic [3:0] r, input logic [63:0] val);
    issue(build(op_mov, r, 4'd0, 4'd0, 1'b1, {1'b0, val[63:48]}), GAP);
    for (int k = 2; k >= 0; k--) begin
      issue(build(op_shl, r, r, 4'd0, 1'b1, 17'd16), GAP);
      issue(build(op_or, r, r, 4'd0, 1'b1, {1'b0, val[k*16 +: 16]}), GAP);
    end
  endtask

  task automatic arithmetic_ops();
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] r;
    test_name = "arith";
    for (int k = 0; k < N_ARITH; k++) begin
      a = rand64();
      b = rand64();
      r = rand64();
      if (k[0]) begin
        a[31:28] = 4'hf;  // carry out of the low half
        b[31:28] = 4'hf;
      end
      if (k[1]) begin
        a[63:61] = 3'b011;
        b[63:61] = (k % 8 < 4) ? 3'b011 : 3'b100;  // add or sub overflow
      end
      load_reg(4'd1, a);
      load_reg(4'd2, b);
      issue(build(op_add, 4'd4, 4'd1, 4'd2, 1'b0, '0), GAP);
      issue(build(op_sub, 4'd5, 4'd1, 4'd2, 1'b0, '0), GAP);
      issue(build(op_add, 4'd6, 4'd1, 4'd0, 1'b1, r[16:0]), GAP);
    end
    issue(build(op_sub, 4'd7, 4'd1, 4'd1, 1'b0, '0), GAP);  // zero result
  endtask

  task automatic logic_and_shifts();
    opcode_e     lg_ops [3] = '{op_and, op_or, op_xor};
    opcode_e     sh_ops [3] = '{op_shl, op_shr, op_sar};
    logic [63:0] r;
    test_name = "logic";
    for (int k = 0; k < N_LOGIC; k++) begin
      load_reg(4'd1, rand64());
      load_reg(4'd2, rand64());
      foreach (lg_ops[s]) begin
        issue(build(lg_ops[s], 4'd3, 4'd1, 4'd2, 1'b0, '0), GAP);
      end
      foreach (sh_ops[s]) begin
        r = rand64();
        issue(build(sh_ops[s], 4'd4, 4'd1, 4'd2, 1'b0, '0), GAP);
        issue(build(sh_ops[s], 4'd4, 4'd1, 4'd0, 1'b1, {11'd0, r[5:0]}), GAP);
      end
      for (int m = 0; m < 4; m++) begin
        issue(build(op_sxt, 4'd5, 4'd1, 4'd0, 1'b1, 17'(m)), GAP);
      end
    end
  endtask

  task automatic predication();
    logic [3:0]  lhs [4] = '{4'd7, 4'd7, 4'd8, 4'd10};
    logic [3:0]  rhs [4] = '{4'd9, 4'd8, 4'd7, 4'd7};
    logic [63:0] r;
    insn_t       i;
    test_name = "predication";
    issue(build(op_mov, 4'd7, 4'd0, 4'd0, 1'b1, 17'd5), GAP);
    issue(build(op_mov, 4'd8, 4'd0, 4'd0, 1'b1, 17'h1fffd), GAP);  // -3
    issue(build(op_mov, 4'd9, 4'd0, 4'd0, 1'b1, 17'd5), GAP);
    issue(build(op_mov, 4'd10, 4'd0, 4'd0, 1'b1, 17'd1), GAP);
    issue(build(op_shl, 4'd10, 4'd10, 4'd0, 1'b1, 17'd63), GAP);  // most negative
    for (int s = 0; s < 4; s++) begin
      for (int c = 0; c < 16; c++) begin
        r = rand64();
        issue(build(op_cmp, 4'd0, lhs[s], rhs[s], 1'b0, '0), GAP);
        i = build(op_mov, 4'd11, 4'd0, 4'd0, 1'b1, r[16:0]);
        i.cond = cond_e'(c);
        issue(i, GAP);
        i = build(op_mov, 4'd12, 4'd0, 4'd11, 1'b0, '0);  // read r11 back
        i.set_flags = 1'b0;
        issue(i, GAP);
      end
    end
  endtask

  // reads r0..r7 and writes r8..r15
  task automatic back_to_back();
    logic [63:0] r;
    insn_t       i;
    test_name = "pipeline";
    for (int k = 0; k < 40; k++) begin
      r = rand64();
      i = build(opcode_e'(5'(r[63:32] % 11)), {1'b1, r[2:0]}, {1'b0, r[5:3]},
                {1'b0, r[8:6]}, r[9], r[26:10]);
      i.set_flags = r[27];
      issue(i, 0);
    end
    idle(1);
  endtask

  task automatic cmp_and_noop();
    logic [4:0] bad [3] = '{5'd11, 5'd20, 5'd31};
    test_name = "cmp_noop";
    issue(build(op_cmp, 4'd1, 4'd2, 4'd3, 1'b0, '0), GAP);
    issue(build(op_mov, 4'd13, 4'd0, 4'd1, 1'b0, '0), GAP);
    foreach (bad[k]) begin
      issue(build(opcode_e'(bad[k]), 4'd1, 4'd2, 4'd3, 1'b0, '0), GAP);
    end
    issue(build(op_mov, 4'd13, 4'd0, 4'd1, 1'b0, '0), GAP);
  endtask

  always @(negedge clk) begin : retire_check
    retire_t want;
    string   name;
    if (!rst && retire.valid) begin
      if (exp_q.size() == 0) begin
        require(1'b0, "retire with no instruction outstanding");
      end else begin
        want = exp_q.pop_front();
        name = name_q.pop_front();
        compare(name, "write", want.write, retire.write);
        compare(name, "rd", want.rd, retire.rd);
        compare(name, "data", want.data, retire.data);
        compare(name, "flags", want.flags, retire.flags);
        compare(name, "flags_write", want.flags_write, retire.flags_write);
      end
    end
  end

  initial begin
    rst          = 1'b1;
    insn_valid   = 1'b1;  // must be ignored while in reset
    insn         = build(op_mov, 4'd3, 4'd0, 4'd0, 1'b1, 17'd1);
    errors       = 0;
    checks       = 0;
    issued       = 0;
    rng_state    = 64'd82;
    shadow_flags = '0;
    for (int r = 0; r < `CORE_NREGS; r++) begin
      shadow[r] = '0;
    end
    test_name = "reset";
    repeat (RESET_CY) begin
      @(negedge clk);
      require(!retire.valid && !retire.write && !retire.flags_write,
              "retire strobes high during reset");
    end
    rst        = 1'b0;
    insn_valid = 1'b0;
    issue(build(op_mov, 4'd3, 4'd0, 4'd3, 1'b0, '0), GAP);
    arithmetic_ops();
    logic_and_shifts();
    predication();
    back_to_back();
    cmp_and_noop();
    idle(2 * `CORE_LATENCY);
    require(exp_q.size() == 0, "instructions issued but never retired");
    $display("checks %0d, errors %0d, instructions %0d", checks, errors, issued);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- source/int_core.sv
// in-order integer core
// decode, two execute stages and commit around one register file

`timescale 1ns/1ps

`include "core_defs.svh"

module int_core import core_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    insn_valid,
  input  insn_t   insn,
  output retire_t retire
);

  logic [`CORE_REG_AW-1:0] rd_addr_a;
  logic [`CORE_REG_AW-1:0] rd_addr_b;
  logic [`CORE_XLEN-1:0]   rd_data_a;
  logic [`CORE_XLEN-1:0]   rd_data_b;
  flags_t                  rf_flags;    // current flags
  logic                    wr_en;
  logic [`CORE_REG_AW-1:0] wr_addr;
  logic [`CORE_XLEN-1:0]   wr_data;
  logic                    flags_wr_en;
  flags_t                  new_flags;
  logic                    dec_valid;
  decoded_t                dec;
  logic                    ex_valid;
  exec_t                   ex;

  reg_file reg_file_i (
    .clk, .rst,
    .rd_addr_a, .rd_addr_b, .rd_data_a, .rd_data_b,
    .flags_out   (rf_flags),
    .wr_en, .wr_addr, .wr_data,
    .flags_wr_en,
    .flags_in    (new_flags)
  );

  insn_decode insn_decode_i (
    .clk, .rst, .insn_valid, .insn,
    .rd_addr_a, .rd_addr_b, .rd_data_a, .rd_data_b,
    .flags_in (rf_flags),
    .dec_valid, .dec
  );

  alu_exec alu_exec_i (.clk, .rst, .dec_valid, .dec, .ex_valid, .ex);

  result_commit result_commit_i (
    .clk, .rst, .ex_valid, .ex,
    .wr_en, .wr_addr, .wr_data, .flags_wr_en,
    .flags_out (new_flags),
    .retire
  );

endmodule

//--- source/result_commit.sv
// result commit stage
// checks the predicate, forms new flags, writes back and retires

`timescale 1ns/1ps

`include "core_defs.svh"

module result_commit import core_pkg::*; (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    ex_valid,
  input  exec_t                   ex,
  output logic                    wr_en,
  output logic [`CORE_REG_AW-1:0] wr_addr,
  output logic [`CORE_XLEN-1:0]   wr_data,
  output logic                    flags_wr_en,
  output flags_t                  flags_out,
  output retire_t                 retire
);

  function automatic logic cond_pass(input cond_e cond, input flags_t f);
    case (cond)
      eq:      return f.z;
      ne:      return !f.z;
      cs:      return f.c;
      cc:      return !f.c;
      mi:      return f.n;
      pl:      return !f.n;
      vs:      return f.v;
      vc:      return !f.v;
      hi:      return f.c && !f.z;
      ls:      return !f.c || f.z;
      ge:      return f.n == f.v;
      lt:      return f.n != f.v;
      gt:      return !f.z && (f.n == f.v);
      le:      return f.z || (f.n != f.v);
      al:      return 1'b1;
      default: return 1'b0;  // nv
    endcase
  endfunction

  logic pass;

  assign pass = cond_pass(ex.cond, ex.flags);  // flags as seen at decode

  assign flags_out.c = ex.carry;
  assign flags_out.v = ex.overflow;
  assign flags_out.n = ex.result[`CORE_XLEN-1];
  assign flags_out.z = (ex.result == '0);

  assign wr_en       = ex_valid && pass && ex.writes_rd;
  assign flags_wr_en = ex_valid && pass && (ex.set_flags || ex.opcode == op_cmp);
  assign wr_addr     = ex.rd;
  assign wr_data     = ex.result;

  always_ff @(posedge clk) begin
    retire.rd    <= ex.rd;
    retire.data  <= ex.result;
    retire.flags <= flags_out;
    if (rst) begin
      retire.valid       <= 1'b0;
      retire.write       <= 1'b0;
      retire.flags_write <= 1'b0;
    end else begin
      retire.valid       <= ex_valid;
      retire.write       <= wr_en;
      retire.flags_write <= flags_wr_en;
    end
  end

endmodule

//--- source/alu_exec.sv
// two-stage integer execute
// stage 1: low half of the adder plus logic, shift, move and sign extend
// stage 2: high half of the adder on the registered carry

`timescale 1ns/1ps

`include "core_defs.svh"

module alu_exec import core_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     dec_valid,
  input  decoded_t dec,
  output logic     ex_valid,
  output exec_t    ex
);

  logic                  is_sub;
  logic                  is_arith;
  logic [`CORE_XLEN-1:0] bx;       // b, inverted for subtract
  logic [`CORE_HALF:0]   lo_sum;   // carry in top bit
  logic [5:0]            shamt;
  logic [`CORE_XLEN-1:0] sxt_res;
  logic [`CORE_XLEN-1:0] misc_res;
  exec_t                 s1_next;

  exec_t                 s1;
  logic                  s1_valid;
  logic                  s1_arith;
  logic [`CORE_HALF-1:0] s1_a_hi;
  logic [`CORE_HALF-1:0] s1_bx_hi;

  logic [`CORE_HALF:0]   hi_sum;
  logic                  hi_ovf;

  assign is_sub   = (dec.opcode == op_sub) || (dec.opcode == op_cmp);
  assign is_arith = is_sub || (dec.opcode == op_add);
  assign bx       = is_sub ? ~dec.b : dec.b;
  assign shamt    = dec.b[5:0];

  assign lo_sum = {1'b0, dec.a[`CORE_HALF-1:0]} + {1'b0, bx[`CORE_HALF-1:0]} + is_sub;

  always_comb begin
    case (dec.b[1:0])
      2'd0:    sxt_res = {{56{dec.a[7]}}, dec.a[7:0]};
      2'd1:    sxt_res = {{48{dec.a[15]}}, dec.a[15:0]};
      2'd2:    sxt_res = {{32{dec.a[31]}}, dec.a[31:0]};
      default: sxt_res = {32'b0, dec.a[7:0], dec.a[15:8], dec.a[23:16], dec.a[31:24]};
    endcase
  end

  always_comb begin
    case (dec.opcode)
      op_and:  misc_res = dec.a & dec.b;
      op_or:   misc_res = dec.a | dec.b;
      op_xor:  misc_res = dec.a ^ dec.b;
      op_shl:  misc_res = dec.a << shamt;
      op_shr:  misc_res = dec.a >> shamt;
      op_sar:  misc_res = `CORE_XLEN'($signed(dec.a) >>> shamt);
      op_mov:  misc_res = dec.b;
      op_sxt:  misc_res = sxt_res;
      default: misc_res = '0;
    endcase
  end

  always_comb begin
    s1_next.opcode    = dec.opcode;
    s1_next.rd        = dec.rd;
    s1_next.cond      = dec.cond;
    s1_next.set_flags = dec.set_flags;
    s1_next.writes_rd = dec.writes_rd;
    s1_next.flags     = dec.flags;
    // adder ops park the low sum here until stage 2
    s1_next.result    = is_arith ? {{(`CORE_XLEN - `CORE_HALF){1'b0}},
                                    lo_sum[`CORE_HALF-1:0]} : misc_res;
    s1_next.carry     = is_arith & lo_sum[`CORE_HALF];  // low half carry
    s1_next.overflow  = 1'b0;
  end

  always_ff @(posedge clk) begin
    s1       <= s1_next;
    s1_arith <= is_arith;
    s1_a_hi  <= dec.a[`CORE_XLEN-1:`CORE_HALF];
    s1_bx_hi <= bx[`CORE_XLEN-1:`CORE_HALF];
    if (rst) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= dec_valid;
    end
  end

  assign hi_sum = {1'b0, s1_a_hi} + {1'b0, s1_bx_hi} + s1.carry;
  // same operand signs, different result sign
  assign hi_ovf = (s1_a_hi[`CORE_HALF-1] == s1_bx_hi[`CORE_HALF-1]) &&
                  (hi_sum[`CORE_HALF-1] != s1_a_hi[`CORE_HALF-1]);

  always_ff @(posedge clk) begin
    ex <= s1;
    if (s1_arith) begin
      ex.result[`CORE_XLEN-1:`CORE_HALF] <= hi_sum[`CORE_HALF-1:0];
      ex.carry                           <= hi_sum[`CORE_HALF];
      ex.overflow                        <= hi_ovf;
    end else begin
      ex.carry    <= 1'b0;
      ex.overflow <= 1'b0;
    end
    if (rst) begin
      ex_valid <= 1'b0;
    end else begin
      ex_valid <= s1_valid;
    end
  end

endmodule

//--- source/insn_decode.sv
// instruction decode stage
// reads operands and flags, picks register or immediate for b,
// and registers the decoded bundle

`timescale 1ns/1ps

`include "core_defs.svh"

module insn_decode import core_pkg::*; (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    insn_valid,
  input  insn_t                   insn,
  output logic [`CORE_REG_AW-1:0] rd_addr_a,
  output logic [`CORE_REG_AW-1:0] rd_addr_b,
  input  logic [`CORE_XLEN-1:0]   rd_data_a,
  input  logic [`CORE_XLEN-1:0]   rd_data_b,
  input  flags_t                  flags_in,
  output logic                    dec_valid,
  output decoded_t                dec
);

  localparam int IMM_W = $bits(insn.imm);

  logic [`CORE_XLEN-1:0] imm_ext;
  logic [`CORE_XLEN-1:0] opnd_b;
  logic                  op_known;

  assign rd_addr_a = insn.ra;
  assign rd_addr_b = insn.rb;

  assign imm_ext = {{(`CORE_XLEN - IMM_W){insn.imm[IMM_W-1]}}, insn.imm};
  assign opnd_b  = insn.use_imm ? imm_ext : rd_data_b;

  always_comb begin
    case (insn.opcode)
      op_add, op_sub, op_cmp,
      op_and, op_or, op_xor,
      op_shl, op_shr, op_sar,
      op_mov, op_sxt: op_known = 1'b1;
      default:        op_known = 1'b0;  // retires as no-op
    endcase
  end

  always_ff @(posedge clk) begin
    dec.opcode    <= insn.opcode;
    dec.rd        <= insn.rd;
    dec.cond      <= insn.cond;
    dec.set_flags <= insn.set_flags & op_known;
    dec.writes_rd <= op_known && (insn.opcode != op_cmp);
    dec.flags     <= flags_in;
    dec.a         <= rd_data_a;
    dec.b         <= opnd_b;
    if (rst) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= insn_valid;
    end
  end

endmodule

//--- source/reg_file.sv
// integer register file
// sixteen 64-bit registers and the flags register
// two combinational read ports, one clocked write port

`timescale 1ns/1ps

`include "core_defs.svh"

module reg_file import core_pkg::*; (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [`CORE_REG_AW-1:0] rd_addr_a,
  input  logic [`CORE_REG_AW-1:0] rd_addr_b,
  output logic [`CORE_XLEN-1:0]   rd_data_a,
  output logic [`CORE_XLEN-1:0]   rd_data_b,
  output flags_t                  flags_out,
  input  logic                    wr_en,
  input  logic [`CORE_REG_AW-1:0] wr_addr,
  input  logic [`CORE_XLEN-1:0]   wr_data,
  input  logic                    flags_wr_en,
  input  flags_t                  flags_in
);

  logic [`CORE_XLEN-1:0] regs [`CORE_NREGS];
  flags_t                flags;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `CORE_NREGS; i++) begin
        regs[i] <= '0;
      end
      flags <= '0;
    end else begin
      if (wr_en) begin
        regs[wr_addr] <= wr_data;
      end
      if (flags_wr_en) begin
        flags <= flags_in;
      end
    end
  end

  // reads see a write only after its edge
  assign rd_data_a = regs[rd_addr_a];
  assign rd_data_b = regs[rd_addr_b];
  assign flags_out = flags;

endmodule

//--- source/core_pkg.sv
// integer core types
// opcodes, condition codes and the bundles passed between pipeline stages

package core_pkg;

  `include "core_defs.svh"

  typedef enum logic [4:0] {
    op_add = 5'd0,
    op_sub = 5'd1,
    op_cmp = 5'd2,  // sub, flags only
    op_and = 5'd3,
    op_or  = 5'd4,
    op_xor = 5'd5,
    op_shl = 5'd6,
    op_shr = 5'd7,
    op_sar = 5'd8,
    op_mov = 5'd9,
    op_sxt = 5'd10  // sign extend or byte swap
  } opcode_e;

  typedef enum logic [3:0] {
    eq, ne, cs, cc, mi, pl, vs, vc,
    hi, ls, ge, lt, gt, le, al, nv
  } cond_e;

  typedef struct packed {
    logic c;
    logic v;
    logic n;
    logic z;
  } flags_t;

  // instruction word, msb first
  typedef struct packed {
    opcode_e                   opcode;
    logic                      use_imm;
    logic [`CORE_REG_AW-1:0]   rd;
    logic [`CORE_REG_AW-1:0]   ra;
    logic [`CORE_REG_AW-1:0]   rb;
    cond_e                     cond;
    logic                      set_flags;
    logic [`CORE_INSN_W-24:0]  imm;  // sign extended
  } insn_t;

  typedef struct packed {
    opcode_e                 opcode;
    logic [`CORE_REG_AW-1:0] rd;
    cond_e                   cond;
    logic                    set_flags;
    logic                    writes_rd;
    flags_t                  flags;  // flags seen at decode
    logic [`CORE_XLEN-1:0]   a;
    logic [`CORE_XLEN-1:0]   b;
  } decoded_t;

  typedef struct packed {
    opcode_e                 opcode;
    logic [`CORE_REG_AW-1:0] rd;
    cond_e                   cond;
    logic                    set_flags;
    logic                    writes_rd;
    flags_t                  flags;
    logic [`CORE_XLEN-1:0]   result;
    logic                    carry;
    logic                    overflow;
  } exec_t;

  typedef struct packed {
    logic                    valid;
    logic                    write;
    logic [`CORE_REG_AW-1:0] rd;
    logic [`CORE_XLEN-1:0]   data;
    flags_t                  flags;
    logic                    flags_write;
  } retire_t;

endpackage

//--- source/core_defs.svh
// integer core global sizes
// data path, register file, instruction word and pipeline depth

`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// data path width
`define CORE_XLEN 64

// width of each half of the split adder
`define CORE_HALF 32

// architectural registers
`define CORE_NREGS 16

// register address width, log2 of CORE_NREGS
`define CORE_REG_AW 4

// instruction word width
`define CORE_INSN_W 40

// clock edges from issue to retire
`define CORE_LATENCY 4

`endif
